/* src.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_load_align.sv
logic/rv_wb_master.sv
logic/rv_core_ctrl.sv
logic/rv_core.sv
dv/tb_rv_core.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_rv_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'No errors'

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_rv_core.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module tb_rv_core;
    localparam int max_words = 256;

    logic                i_clk;
    logic                i_rst;
    logic                i_ack;
    logic                i_stall;
    logic [`RV_XLEN-1:0] i_data;
    logic                o_cyc;
    logic                o_stb;
    logic [`RV_XLEN-1:0] o_addr;

    logic [`RV_XLEN-1:0] prog [max_words];
    logic [`RV_XLEN-1:0] exp_addr [max_words];
    string               exp_name [max_words];
    int                  prog_len;
    int                  exp_len;
    int                  seen;
    int                  errors;
    logic                table_ready;
    logic [31:0]         lcg_state;

    rv_core DUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opcode, input logic [4:0] rd,
                                          input logic [2:0] funct3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, rv_pkg::opcode_op_reg};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] funct3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], rv_pkg::opcode_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opcode, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::opcode_jal};
    endfunction

    function automatic logic [31:0] here();
        return `RV_PC_RESET + prog_len * `RV_INSN_BYTES;
    endfunction

    // program words inside the image and an address-derived fill elsewhere
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] offset;
        int          idx;
        offset = addr - `RV_PC_RESET;
        idx    = int'(offset >> 2);
        if ((addr >= `RV_PC_RESET) && (idx < prog_len)) begin
            return prog[idx];
        end else begin
            return 32'h8081_F27F ^ {addr[31:2], 2'b00};
        end
    endfunction

    task automatic expect_addr(input string name, input logic [31:0] addr);
        exp_addr[exp_len] = addr;
        exp_name[exp_len] = name;
        exp_len++;
    endtask

    task automatic emit(input string name, input logic [31:0] word);
        expect_addr(name, here());
        prog[prog_len] = word;
        prog_len++;
    endtask

    // words the core must jump over
    task automatic skip_words(input int count);
        repeat (count) begin
            prog[prog_len] = enc_i(rv_pkg::opcode_op_imm, 5'd31, 3'd0, 5'd0, 12'd1);
            prog_len++;
        end
    endtask

    // lw x0 from rs puts the register value on the bus
    task automatic expose(input string name, input logic [4:0] rs, input logic [31:0] value);
        emit(name, enc_i(rv_pkg::opcode_load, 5'd0, 3'd2, rs, 12'd0));
        expect_addr(name, value);
    endtask

    task automatic imm_op(input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm, input logic [31:0] value);
        emit("alu_imm", enc_i(rv_pkg::opcode_op_imm, rd, funct3, rs1, imm));
        expose("alu_imm", rd, value);
    endtask

    task automatic reg_op(input logic [6:0] funct7, input logic [2:0] funct3,
                          input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [31:0] value);
        emit("alu_reg", enc_r(funct7, funct3, rd, rs1, rs2));
        expose("alu_reg", rd, value);
    endtask

    task automatic branch_op(input logic [2:0] funct3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic taken);
        emit("branch_jump", enc_b(funct3, rs1, rs2, 13'd8));
        if (taken) begin
            skip_words(1);
        end
    endtask

    task automatic load_lane(input logic [2:0] funct3, input logic [11:0] off,
                             input logic [31:0] value);
        emit("load_align", enc_i(rv_pkg::opcode_load, 5'd28, funct3, 5'd0, off));
        expect_addr("load_align", {20'd0, off});
        expose("load_align", 5'd28, value);
    endtask

    task automatic build_program();
        logic [31:0] pc_j;
        logic [31:0] pc_a;
        repeat (3) begin
            emit("reset_fetch", enc_i(rv_pkg::opcode_op_imm, 5'd0, 3'd0, 5'd0, 12'd0));
        end
        emit("alu_imm", enc_u(rv_pkg::opcode_lui, 5'd1, 20'h12345));
        expose("alu_imm", 5'd1, 32'h1234_5000);
        imm_op(3'd0, 5'd2, 5'd1, 12'h678, 32'h1234_5678);
        imm_op(3'd0, 5'd3, 5'd0, 12'hFFF, 32'hFFFF_FFFF);
        imm_op(3'd4, 5'd4, 5'd2, 12'h0F0, 32'h1234_5688);
        imm_op(3'd4, 5'd5, 5'd2, 12'hFFF, 32'hEDCB_A987);
        imm_op(3'd6, 5'd6, 5'd2, 12'h700, 32'h1234_5778);
        imm_op(3'd7, 5'd7, 5'd2, 12'h0FF, 32'h0000_0078);
        imm_op(3'd2, 5'd8, 5'd3, 12'h000, 32'h0000_0001);
        imm_op(3'd3, 5'd9, 5'd3, 12'h005, 32'h0000_0000);
        imm_op(3'd1, 5'd10, 5'd2, 12'h004, 32'h2345_6780);
        imm_op(3'd5, 5'd11, 5'd5, 12'h008, 32'h00ED_CBA9);
        imm_op(3'd5, 5'd12, 5'd5, 12'h408, 32'hFFED_CBA9);
        // x13 = 0x123, x14 = 44 so shifts use 12
        emit("alu_reg", enc_i(rv_pkg::opcode_op_imm, 5'd13, 3'd0, 5'd0, 12'h123));
        emit("alu_reg", enc_i(rv_pkg::opcode_op_imm, 5'd14, 3'd0, 5'd0, 12'd44));
        reg_op(7'h00, 3'd0, 5'd15, 5'd2, 5'd13, 32'h1234_579B);
        reg_op(7'h20, 3'd0, 5'd16, 5'd2, 5'd13, 32'h1234_5555);
        reg_op(7'h00, 3'd1, 5'd17, 5'd2, 5'd14, 32'h4567_8000);
        reg_op(7'h00, 3'd5, 5'd18, 5'd5, 5'd14, 32'h000E_DCBA);
        reg_op(7'h20, 3'd5, 5'd19, 5'd5, 5'd14, 32'hFFFE_DCBA);
        reg_op(7'h00, 3'd2, 5'd20, 5'd5, 5'd2, 32'h0000_0001);
        reg_op(7'h00, 3'd3, 5'd21, 5'd5, 5'd2, 32'h0000_0000);
        reg_op(7'h00, 3'd4, 5'd22, 5'd2, 5'd13, 32'h1234_575B);
        reg_op(7'h00, 3'd6, 5'd23, 5'd2, 5'd13, 32'h1234_577B);
        reg_op(7'h00, 3'd7, 5'd24, 5'd2, 5'd13, 32'h0000_0020);
        reg_op(7'h00, 3'd0, 5'd0, 5'd2, 5'd13, 32'h0000_0000);
        // x2 big positive, x13 small, x3 = -1, x8 = 1
        branch_op(3'd0, 5'd2, 5'd2, 1'b1);
        branch_op(3'd0, 5'd2, 5'd13, 1'b0);
        branch_op(3'd1, 5'd2, 5'd13, 1'b1);
        branch_op(3'd1, 5'd2, 5'd2, 1'b0);
        branch_op(3'd4, 5'd3, 5'd8, 1'b1);
        branch_op(3'd4, 5'd8, 5'd3, 1'b0);
        branch_op(3'd5, 5'd8, 5'd3, 1'b1);
        branch_op(3'd5, 5'd3, 5'd8, 1'b0);
        branch_op(3'd6, 5'd8, 5'd3, 1'b1);
        branch_op(3'd6, 5'd3, 5'd8, 1'b0);
        branch_op(3'd7, 5'd3, 5'd8, 1'b1);
        branch_op(3'd7, 5'd8, 5'd3, 1'b0);
        pc_j = here();
        emit("branch_jump", enc_j(5'd1, 21'd12));
        skip_words(2);
        expose("branch_jump", 5'd1, pc_j + 32'd4);
        pc_a = here();
        emit("branch_jump", enc_u(rv_pkg::opcode_auipc, 5'd25, 20'h00000));
        emit("branch_jump", enc_u(rv_pkg::opcode_auipc, 5'd26, 20'h00001));
        expose("branch_jump", 5'd26, pc_a + 32'd4 + 32'h0000_1000);
        expose("branch_jump", 5'd25, pc_a);
        // odd offset so bit 0 of the target gets cleared
        emit("branch_jump", enc_i(rv_pkg::opcode_jalr, 5'd27, 3'd0, 5'd25, 12'd25));
        skip_words(1);
        expose("branch_jump", 5'd27, pc_a + 32'd20);
        load_lane(3'd0, 12'd0, 32'h0000_007F);
        load_lane(3'd0, 12'd1, 32'hFFFF_FFF2);
        load_lane(3'd0, 12'd2, 32'hFFFF_FF81);
        load_lane(3'd0, 12'd3, 32'hFFFF_FF80);
        load_lane(3'd4, 12'd0, 32'h0000_007F);
        load_lane(3'd4, 12'd1, 32'h0000_00F2);
        load_lane(3'd4, 12'd2, 32'h0000_0081);
        load_lane(3'd4, 12'd3, 32'h0000_0080);
        load_lane(3'd1, 12'd0, 32'hFFFF_F27F);
        load_lane(3'd1, 12'd2, 32'hFFFF_8081);
        load_lane(3'd5, 12'd0, 32'h0000_F27F);
        load_lane(3'd5, 12'd2, 32'h0000_8081);
        load_lane(3'd2, 12'd0, 32'h8081_F27F);
        emit("load_align", enc_i(rv_pkg::opcode_load, 5'd29, 3'd2, 5'd24, 12'd0));
        expect_addr("load_align", 32'h0000_0020);
        expose("load_align", 5'd29, 32'h8081_F25F);
        emit("stall", enc_i(rv_pkg::opcode_op_imm, 5'd30, 3'd0, 5'd0, 12'h555));
        expose("stall", 5'd30, 32'h0000_0555);
        // ecall, fence and an unknown opcode all run as nops
        emit("stall", 32'h0000_0073);
        emit("stall", 32'h0000_000F);
        emit("stall", 32'h0000_0F7F);
        expose("stall", 5'd30, 32'h0000_0555);
        emit("stall", enc_i(rv_pkg::opcode_op_imm, 5'd30, 3'd0, 5'd30, 12'hAAA));
        expose("stall", 5'd30, 32'hFFFF_FFFF);
    endtask

    task automatic check_bus_addr(input logic [31:0] addr);
        if (seen < exp_len) begin
            if (addr !== exp_addr[seen]) begin
                errors++;
                $display("CHECK FAILED %s: bus cycle %0d expected address %h, actual %h",
                         exp_name[seen], seen, exp_addr[seen], addr);
            end
            seen++;
        end
    endtask

    task automatic check_held(input logic [31:0] addr);
        if (o_stb !== 1'b1) begin
            errors++;
            $display("strobe dropped at %0t while the slave was stalling", $time);
        end else if (o_addr !== addr) begin
            errors++;
            $display("CHECK FAILED stall: expected address %h, actual %h", addr, o_addr);
        end
    endtask

    // cycle closes and the address clears right after the ack
    task automatic check_released();
        if ((o_cyc !== 1'b0) || (o_addr !== '0)) begin
            errors++;
            $display("CHECK FAILED stall: after ack expected cyc 0 addr %h, actual %b %h",
                     32'h0, o_cyc, o_addr);
        end
    endtask

    // slave model with a random stall and ack delay per request
    initial begin : bus_slave
        logic [31:0] req_addr;
        int          stall_cycles;
        int          ack_delay;
        forever begin
            @(negedge i_clk);
            if ((o_cyc === 1'b1) && (o_stb === 1'b1)) begin
                req_addr     = o_addr;
                check_bus_addr(req_addr);
                stall_cycles = int'(next_rand() % 4);
                ack_delay    = int'(next_rand() % 4);
                repeat (stall_cycles) begin
                    i_stall = 1'b1;
                    @(negedge i_clk);
                    check_held(req_addr);
                end
                i_stall = 1'b0;
                @(negedge i_clk);
                repeat (ack_delay) @(negedge i_clk);
                i_ack  = 1'b1;
                i_data = mem_word(req_addr);
                @(negedge i_clk);
                i_ack  = 1'b0;
                check_released();
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (40 * exp_len * 12) @(posedge i_clk);
        $display("watchdog expired, the run hung after %0d of %0d bus cycles, %0d errors",
                 seen, exp_len, errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        i_rst       = 1'b1;
        i_ack       = 1'b0;
        i_stall     = 1'b0;
        i_data      = '0;
        lcg_state   = 32'd43934;
        prog_len    = 0;
        exp_len     = 0;
        seen        = 0;
        errors      = 0;
        table_ready = 1'b0;
        build_program();
        table_ready = 1'b1;
        repeat (5) @(negedge i_clk);
        if ((o_cyc !== 1'b0) || (o_stb !== 1'b0) || (o_addr !== '0)) begin
            errors++;
            $display("CHECK FAILED reset_fetch: expected cyc 0 stb 0 addr %h, actual %b %b %h",
                     32'h0, o_cyc, o_stb, o_addr);
        end
        i_rst = 1'b0;
        @(negedge i_clk);
        if (o_stb !== 1'b1) begin
            errors++;
            $display("first fetch strobe did not rise in the first cycle after reset");
        end
        wait (seen == exp_len);
        repeat (2) @(negedge i_clk);
        $display("%0d of %0d bus cycles checked, %0d errors", seen, exp_len, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_ack,
    input  logic                i_stall,
    input  logic [`RV_XLEN-1:0] i_data,
    output logic                o_cyc,
    output logic                o_stb,
    output logic [`RV_XLEN-1:0] o_addr
);
    logic                req_valid;
    rv_pkg::rv_bus_req_t req;
    logic                rsp_valid;
    logic [`RV_XLEN-1:0] rsp_data;
    rv_pkg::rv_instr_u   fetched;
    rv_pkg::rv_decoded_t decoded;
    rv_pkg::rv_decoded_t dec_q;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_result;
    logic                branch_taken;
    logic [`RV_XLEN-1:0] load_value;
    logic                rf_we;
    logic [4:0]          rf_waddr;
    logic [`RV_XLEN-1:0] rf_wdata;

    rv_core_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rsp_valid    (rsp_valid),
        .i_rsp_data     (rsp_data),
        .i_decoded      (decoded),
        .i_alu_result   (alu_result),
        .i_branch_taken (branch_taken),
        .i_load_value   (load_value),
        .o_req_valid    (req_valid),
        .o_req          (req),
        .o_fetched      (fetched),
        .o_dec_q        (dec_q),
        .o_pc           (pc),
        .o_rf_we        (rf_we),
        .o_rf_waddr     (rf_waddr),
        .o_rf_wdata     (rf_wdata)
    );

    rv_decoder u_decoder (
        .i_instr   (fetched),
        .o_decoded (decoded)
    );

    rv_regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs1     (dec_q.rs1),
        .i_rs2     (dec_q.rs2),
        .i_we      (rf_we),
        .i_waddr   (rf_waddr),
        .i_wdata   (rf_wdata),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val)
    );

    rv_alu u_alu (
        .i_decoded      (dec_q),
        .i_rs1_val      (rs1_val),
        .i_rs2_val      (rs2_val),
        .i_pc           (pc),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    // the load address stays on the alu output until write-back
    rv_load_align u_load_align (
        .i_word    (rsp_data),
        .i_addr_lo (alu_result[1:0]),
        .i_funct3  (dec_q.funct3),
        .o_value   (load_value)
    );

    rv_wb_master u_wb_master (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (req_valid),
        .i_req       (req),
        .i_ack       (i_ack),
        .i_stall     (i_stall),
        .i_data      (i_data),
        .o_cyc       (o_cyc),
        .o_stb       (o_stb),
        .o_addr      (o_addr),
        .o_rsp_valid (rsp_valid),
        .o_rsp_data  (rsp_data)
    );

endmodule

/* logic/rv_core_ctrl.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core_ctrl (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_rsp_valid,
    input  logic [`RV_XLEN-1:0] i_rsp_data,
    input  rv_pkg::rv_decoded_t i_decoded,
    input  logic [`RV_XLEN-1:0] i_alu_result,
    input  logic                i_branch_taken,
    input  logic [`RV_XLEN-1:0] i_load_value,
    output logic                o_req_valid,
    output rv_pkg::rv_bus_req_t o_req,
    output rv_pkg::rv_instr_u   o_fetched,
    output rv_pkg::rv_decoded_t o_dec_q,
    output logic [`RV_XLEN-1:0] o_pc,
    output logic                o_rf_we,
    output logic [4:0]          o_rf_waddr,
    output logic [`RV_XLEN-1:0] o_rf_wdata
);
    localparam logic [1:0] st_fetch  = 2'd0;
    localparam logic [1:0] st_decode = 2'd1;
    localparam logic [1:0] st_exec   = 2'd2;
    localparam logic [1:0] st_access = 2'd3;

    logic [1:0]          state;
    logic                fetch_sent;
    logic                is_load;
    logic                is_link;
    logic                writes_rd;
    logic [`RV_XLEN-1:0] pc_step;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] pc_next;

    assign is_load   = (o_dec_q.opclass == rv_pkg::opc_load);
    assign is_link   = (o_dec_q.opclass inside {rv_pkg::opc_jal, rv_pkg::opc_jalr});
    // nops arrive with rd already forced to x0
    assign writes_rd = !(o_dec_q.opclass inside {rv_pkg::opc_branch, rv_pkg::opc_load});
    assign pc_step   = o_pc + `RV_INSN_BYTES;
    assign pc_target = o_pc + o_dec_q.imm;

    always_comb begin
        case (o_dec_q.opclass)
            rv_pkg::opc_jal:    pc_next = pc_target;
            rv_pkg::opc_jalr:   pc_next = {i_alu_result[`RV_XLEN-1:1], 1'b0};
            rv_pkg::opc_branch: pc_next = i_branch_taken ? pc_target : pc_step;
            default:            pc_next = pc_step;
        endcase
    end

    // fetch uses the pc, a load the rs1 + imm sum
    assign o_req_valid = ((state == st_fetch) && !fetch_sent) || ((state == st_exec) && is_load);
    assign o_req.addr  = (state == st_fetch) ? o_pc : i_alu_result;

    assign o_rf_we    = ((state == st_exec) && writes_rd) || ((state == st_access) && i_rsp_valid);
    assign o_rf_waddr = o_dec_q.rd;
    assign o_rf_wdata = (state == st_access) ? i_load_value :
                        is_link ? pc_step : i_alu_result;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= st_fetch;
            fetch_sent <= 1'b0;
            o_pc       <= `RV_PC_RESET;
        end else begin
            case (state)
                st_fetch: begin
                    if (o_req_valid) begin
                        fetch_sent <= 1'b1;
                    end
                    if (i_rsp_valid) begin
                        fetch_sent <= 1'b0;
                        state      <= st_decode;
                    end
                end
                st_decode: state <= st_exec;
                st_exec: begin
                    o_pc  <= pc_next;
                    state <= is_load ? st_access : st_fetch;
                end
                default: begin
                    if (i_rsp_valid) begin
                        state <= st_fetch;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if ((state == st_fetch) && i_rsp_valid) begin
            o_fetched <= i_rsp_data;
        end
        if (state == st_decode) begin
            o_dec_q <= i_decoded;
        end
    end

    // bus master must be idle again before the next request
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_req_valid |=> !o_req_valid until i_rsp_valid);

endmodule

/* logic/rv_wb_master.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_wb_master (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_req_valid,
    input  rv_pkg::rv_bus_req_t i_req,
    input  logic                i_ack,
    input  logic                i_stall,
    input  logic [`RV_XLEN-1:0] i_data,
    output logic                o_cyc,
    output logic                o_stb,
    output logic [`RV_XLEN-1:0] o_addr,
    output logic                o_rsp_valid,
    output logic [`RV_XLEN-1:0] o_rsp_data
);
    logic ack_ok;

    // ack only counts while the slave is not stalling
    assign ack_ok = o_cyc && i_ack && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cyc       <= 1'b0;
            o_stb       <= 1'b0;
            o_addr      <= '0;
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= ack_ok;
            if (i_req_valid) begin
                o_cyc  <= 1'b1;
                o_stb  <= 1'b1;
                o_addr <= i_req.addr;
            end else begin
                if (o_stb && !i_stall) begin
                    o_stb <= 1'b0;
                end
                if (ack_ok) begin
                    o_cyc  <= 1'b0;
                    o_addr <= '0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (ack_ok) begin
            o_rsp_data <= i_data;
        end
    end

    assert property (@(posedge i_clk) disable iff (i_rst) o_stb |-> o_cyc);

    // a stalled strobe keeps its address
    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_stb && i_stall) |=> (o_stb && $stable(o_addr)));

endmodule

/* logic/rv_load_align.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_load_align (
    input  logic [`RV_XLEN-1:0] i_word,
    input  logic [1:0]          i_addr_lo,
    input  logic [2:0]          i_funct3,
    output logic [`RV_XLEN-1:0] o_value
);
    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // little endian lanes
    assign byte_val = i_word[{i_addr_lo, 3'b000} +: 8];
    assign half_val = i_addr_lo[1] ? i_word[31:16] : i_word[15:0];

    always_comb begin
        case (i_funct3)
            3'b000:  o_value = {{(`RV_XLEN-8){byte_val[7]}}, byte_val};
            3'b001:  o_value = {{(`RV_XLEN-16){half_val[15]}}, half_val};
            3'b100:  o_value = {{(`RV_XLEN-8){1'b0}}, byte_val};
            3'b101:  o_value = {{(`RV_XLEN-16){1'b0}}, half_val};
            default: o_value = i_word;
        endcase
    end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_alu (
    input  rv_pkg::rv_decoded_t i_decoded,
    input  logic [`RV_XLEN-1:0] i_rs1_val,
    input  logic [`RV_XLEN-1:0] i_rs2_val,
    input  logic [`RV_XLEN-1:0] i_pc,
    output logic [`RV_XLEN-1:0] o_result,
    output logic                o_branch_taken
);
    logic                use_imm;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] sra_val;
    logic                lt;
    logic                ltu;
    logic                cond;

    assign use_imm = (i_decoded.opclass inside {rv_pkg::opc_op_imm, rv_pkg::opc_load,
                                                rv_pkg::opc_jalr, rv_pkg::opc_auipc});
    assign op_a    = (i_decoded.opclass == rv_pkg::opc_auipc) ? i_pc : i_rs1_val;
    assign op_b    = use_imm ? i_decoded.imm : i_rs2_val;
    assign shamt   = op_b[4:0];
    assign sra_val = $unsigned($signed(op_a) >>> shamt);

    // shared by slt/sltu and the branch compares
    assign lt  = $signed(op_a) < $signed(op_b);
    assign ltu = op_a < op_b;

    always_comb begin
        case (i_decoded.opclass)
            rv_pkg::opc_lui: o_result = i_decoded.imm;
            rv_pkg::opc_op_imm, rv_pkg::opc_op_reg: begin
                case (i_decoded.funct3)
                    3'b000: begin
                        if ((i_decoded.opclass == rv_pkg::opc_op_reg) && i_decoded.alt) begin
                            o_result = op_a - op_b;
                        end else begin
                            o_result = op_a + op_b;
                        end
                    end
                    3'b001:  o_result = op_a << shamt;
                    3'b010:  o_result = {{(`RV_XLEN-1){1'b0}}, lt};
                    3'b011:  o_result = {{(`RV_XLEN-1){1'b0}}, ltu};
                    3'b100:  o_result = op_a ^ op_b;
                    3'b101:  o_result = i_decoded.alt ? sra_val : (op_a >> shamt);
                    3'b110:  o_result = op_a | op_b;
                    default: o_result = op_a & op_b;
                endcase
            end
            default: o_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (i_decoded.funct3)
            3'b000:  cond = (op_a == op_b);
            3'b001:  cond = (op_a != op_b);
            3'b100:  cond = lt;
            3'b101:  cond = !lt;
            3'b110:  cond = ltu;
            3'b111:  cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = (i_decoded.opclass == rv_pkg::opc_branch) && cond;

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_regfile (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic [4:0]          i_rs1,
    input  logic [4:0]          i_rs2,
    input  logic                i_we,
    input  logic [4:0]          i_waddr,
    input  logic [`RV_XLEN-1:0] i_wdata,
    output logic [`RV_XLEN-1:0] o_rs1_val,
    output logic [`RV_XLEN-1:0] o_rs2_val
);
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rs1_val = regs[i_rs1];
    assign o_rs2_val = regs[i_rs2];

    // x0 stays zero whatever the controller writes
    assert property (@(posedge i_clk) disable iff (i_rst) regs[0] == '0);

endmodule

/* logic/rv_decoder.sv */
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_decoder (
    input  rv_pkg::rv_instr_u   i_instr,
    output rv_pkg::rv_decoded_t o_decoded
);
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign imm_i = {{(`RV_XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};
    assign imm_b = {{(`RV_XLEN-13){i_instr.b.imm_12}}, i_instr.b.imm_12, i_instr.b.imm_11,
                    i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
    assign imm_u = {i_instr.u.imm, 12'b0};
    assign imm_j = {{(`RV_XLEN-21){i_instr.j.imm_20}}, i_instr.j.imm_20, i_instr.j.imm_19_12,
                    i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};

    always_comb begin
        o_decoded.opclass = rv_pkg::opc_nop;
        o_decoded.funct3  = i_instr.r.funct3;
        o_decoded.alt     = i_instr.r.funct7[5];
        o_decoded.rd      = i_instr.r.rd;
        o_decoded.rs1     = i_instr.r.rs1;
        o_decoded.rs2     = i_instr.r.rs2;
        o_decoded.imm     = imm_i;
        case (i_instr.r.opcode)
            rv_pkg::opcode_lui: begin
                o_decoded.opclass = rv_pkg::opc_lui;
                o_decoded.imm     = imm_u;
            end
            rv_pkg::opcode_auipc: begin
                o_decoded.opclass = rv_pkg::opc_auipc;
                o_decoded.imm     = imm_u;
            end
            rv_pkg::opcode_jal: begin
                o_decoded.opclass = rv_pkg::opc_jal;
                o_decoded.imm     = imm_j;
            end
            rv_pkg::opcode_branch: begin
                o_decoded.opclass = rv_pkg::opc_branch;
                o_decoded.imm     = imm_b;
            end
            rv_pkg::opcode_jalr:   o_decoded.opclass = rv_pkg::opc_jalr;
            rv_pkg::opcode_op_imm: o_decoded.opclass = rv_pkg::opc_op_imm;
            rv_pkg::opcode_load:   o_decoded.opclass = rv_pkg::opc_load;
            rv_pkg::opcode_op_reg: o_decoded.opclass = rv_pkg::opc_op_reg;
            // fence, system and unknown words fall through as nops
            default: o_decoded.rd = '0;
        endcase
    end

endmodule

/* logic/rv_pkg.sv */
`include "rv_cfg.svh"

package rv_pkg;

    // major opcodes of the kept instruction classes
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op_reg = 7'b0110011;
    localparam logic [6:0] opcode_load   = 7'b0000011;

    typedef enum logic [3:0] {
        opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch,
        opc_op_imm, opc_op_reg, opc_load, opc_nop
    } rv_opclass_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // one instruction word seen through each encoding format
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
        rv_b_fmt_t b;
        rv_u_fmt_t u;
        rv_j_fmt_t j;
    } rv_instr_u;

    typedef struct packed {
        rv_opclass_e         opclass;
        logic [2:0]          funct3;
        logic                alt;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
    } rv_decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
    } rv_bus_req_t;

endpackage

/* logic/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address after reset
`define RV_PC_RESET   32'h2040_0000

`define RV_XLEN       32
`define RV_NREGS      32

// pc step between sequential instructions
`define RV_INSN_BYTES 4

`endif
